//--- hw/spi_flash_pkg.sv
package spi_flash_pkg;

    typedef logic [23:0] flash_addr_t;  // flash byte address
    typedef logic [31:0] flash_word_t;  // four bytes, first byte in 31..24
    typedef logic [4:0]  wb_addr_t;     // wishbone byte offset

    // flash opcodes
    localparam logic [7:0] OP_READ  = 8'h03;
    localparam logic [7:0] OP_QREAD = 8'h6B;  // fast read, quad output
    localparam logic [7:0] OP_WREN  = 8'h06;
    localparam logic [7:0] OP_PP    = 8'h02;
    localparam logic [7:0] OP_RDSR  = 8'h05;

    // host command codes, bits 1..0 of the control register
    localparam logic [1:0] CMD_READ    = 2'd0;
    localparam logic [1:0] CMD_QREAD   = 2'd1;
    localparam logic [1:0] CMD_PROGRAM = 2'd2;
    localparam logic [1:0] CMD_STATUS  = 2'd3;

    // register map
    localparam wb_addr_t REG_CTRL   = 5'h00;
    localparam wb_addr_t REG_ADDR   = 5'h04;
    localparam wb_addr_t REG_WDATA  = 5'h08;
    localparam wb_addr_t REG_RDATA  = 5'h0C;
    localparam wb_addr_t REG_STATUS = 5'h10;

    // one state per frame type
    typedef enum logic [2:0] {
        IDLE,
        WREN,
        PROGRAM,
        POLL,
        READ,
        QREAD,
        STATUS,
        DONE
    } seq_state_t;

    localparam int QUAD_DUMMY_BYTES = 1;  // eight dummy clocks for 6Bh

endpackage

//--- hw/spi_shifter.sv
`timescale 1ns/1ps

module spi_shifter import spi_flash_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        phase_start,
    input  logic        phase_rx,
    input  logic        phase_quad,
    input  logic [2:0]  phase_bytes,
    input  flash_word_t phase_tx,
    output logic        phase_done,
    output flash_word_t phase_rx_word,
    output logic        sck,
    output logic [3:0]  dq_out,
    output logic [3:0]  dq_oe,
    input  logic [3:0]  dq_in
);

    flash_word_t tx_sr;      // left-aligned, msb goes out first
    flash_word_t rx_sr;      // fills from the lsb end
    logic [5:0]  unit_cnt;   // bits (single) or nibbles (quad) still to move
    logic        active;
    logic        rx_mode;
    logic        quad_mode;
    logic        sck_q;
    logic        drive;

    assign sck           = sck_q;
    assign phase_rx_word = rx_sr;
    assign drive         = active && !rx_mode;

    // last unit ends on the falling half, rx word already complete
    assign phase_done = active && sck_q && (unit_cnt == 6'd1);

    assign dq_oe = drive ? (quad_mode ? 4'b1111 : 4'b0001) : 4'b0000;

    always_comb begin
        dq_out = 4'b0000;
        if (drive) begin
            if (quad_mode) begin
                dq_out = tx_sr[31:28];         // high nibble first
            end else begin
                dq_out = {3'b000, tx_sr[31]};  // single mode sends on dq0
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            active    <= 1'b0;
            sck_q     <= 1'b0;
            unit_cnt  <= 6'd0;
            rx_mode   <= 1'b0;
            quad_mode <= 1'b0;
        end else if (!active) begin
            if (phase_start) begin
                active    <= 1'b1;
                rx_mode   <= phase_rx;
                quad_mode <= phase_quad;
                if (phase_quad) begin
                    unit_cnt <= {2'b00, phase_bytes, 1'b0};  // two nibbles per byte
                end else begin
                    unit_cnt <= {phase_bytes, 3'b000};       // eight bits per byte
                end
            end
        end else if (!sck_q) begin
            sck_q <= 1'b1;  // rising edge, flash samples here
        end else begin
            sck_q    <= 1'b0;
            unit_cnt <= unit_cnt - 6'd1;
            if (unit_cnt == 6'd1) begin
                active <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!active) begin
            if (phase_start) begin
                tx_sr <= phase_tx;
                rx_sr <= '0;
            end
        end else if (!sck_q) begin
            // sample on the cycle that raises sck
            if (rx_mode) begin
                if (quad_mode) begin
                    rx_sr <= {rx_sr[27:0], dq_in};
                end else begin
                    rx_sr <= {rx_sr[30:0], dq_in[1]};  // flash answers on dq1
                end
            end
        end else begin
            // advance while sck drops, data settles during the low half
            if (quad_mode) begin
                tx_sr <= {tx_sr[27:0], 4'h0};
            end else begin
                tx_sr <= {tx_sr[30:0], 1'b0};
            end
        end
    end

endmodule

//--- hw/flash_sequencer.sv
`timescale 1ns/1ps

module flash_sequencer import spi_flash_pkg::*; #(
    parameter int POLL_LIMIT = 64
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        cmd_start,
    input  logic [1:0]  cmd_code,
    input  flash_addr_t cmd_addr,
    input  flash_word_t cmd_wdata,
    input  logic        phase_done,
    input  flash_word_t phase_rx_word,
    output logic        phase_start,
    output logic        phase_rx,
    output logic        phase_quad,
    output logic [2:0]  phase_bytes,
    output flash_word_t phase_tx,
    output logic        cs_n,
    output logic        busy,
    output logic        cmd_done,
    output flash_word_t rdata,
    output logic        rdata_valid,
    output logic [7:0]  flash_status,
    output logic        error
);

    localparam int PW = $clog2(POLL_LIMIT + 1);

    seq_state_t    state;
    logic [1:0]    phase_idx;
    logic          in_phase;
    logic          gap;         // keeps cs_n high between frames
    logic [PW-1:0] poll_cnt;
    flash_addr_t   addr_q;
    flash_word_t   wdata_q;
    logic          last_phase;
    logic          frame_end;

    assign frame_end = in_phase && phase_done && last_phase;

    // phase table, indexed by frame and phase number
    always_comb begin
        phase_rx    = 1'b0;
        phase_quad  = 1'b0;
        phase_bytes = 3'd1;
        phase_tx    = {OP_RDSR, 24'h000000};
        last_phase  = 1'b0;
        case (state)
            WREN: begin
                phase_tx   = {OP_WREN, 24'h000000};
                last_phase = 1'b1;
            end
            PROGRAM: begin
                case (phase_idx)
                    2'd0: phase_tx = {OP_PP, 24'h000000};
                    2'd1: begin
                        phase_tx    = {addr_q, 8'h00};
                        phase_bytes = 3'd3;
                    end
                    default: begin
                        phase_tx    = wdata_q;
                        phase_bytes = 3'd4;
                        last_phase  = 1'b1;
                    end
                endcase
            end
            READ, QREAD: begin
                case (phase_idx)
                    2'd0: phase_tx = {(state == QREAD) ? OP_QREAD : OP_READ, 24'h000000};
                    2'd1: begin
                        phase_tx    = {addr_q, 8'h00};
                        phase_bytes = 3'd3;
                    end
                    2'd2: begin
                        phase_rx = 1'b1;
                        if (state == QREAD) begin
                            phase_bytes = 3'(QUAD_DUMMY_BYTES);  // dummy clocks, data dropped
                        end else begin
                            phase_bytes = 3'd4;
                            last_phase  = 1'b1;
                        end
                    end
                    default: begin
                        phase_rx    = 1'b1;
                        phase_quad  = 1'b1;
                        phase_bytes = 3'd4;
                        last_phase  = 1'b1;
                    end
                endcase
            end
            POLL, STATUS: begin
                if (phase_idx != 2'd0) begin
                    phase_rx   = 1'b1;
                    last_phase = 1'b1;
                end
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= IDLE;
            phase_idx    <= 2'd0;
            in_phase     <= 1'b0;
            gap          <= 1'b0;
            poll_cnt     <= '0;
            phase_start  <= 1'b0;
            cs_n         <= 1'b1;
            busy         <= 1'b0;
            cmd_done     <= 1'b0;
            rdata_valid  <= 1'b0;
            flash_status <= 8'h00;
            error        <= 1'b0;
        end else begin
            phase_start <= 1'b0;
            cmd_done    <= 1'b0;
            rdata_valid <= 1'b0;
            case (state)
                IDLE: begin
                    if (cmd_start) begin
                        busy      <= 1'b1;
                        error     <= 1'b0;
                        poll_cnt  <= '0;
                        phase_idx <= 2'd0;
                        gap       <= 1'b0;
                        case (cmd_code)
                            CMD_READ:    state <= READ;
                            CMD_QREAD:   state <= QREAD;
                            CMD_PROGRAM: state <= WREN;  // write enable comes first
                            CMD_STATUS:  state <= STATUS;
                        endcase
                    end
                end
                DONE: begin
                    busy     <= 1'b0;
                    cmd_done <= 1'b1;
                    state    <= IDLE;
                end
                default: begin
                    if (gap) begin
                        gap <= 1'b0;
                    end else if (!in_phase) begin
                        phase_start <= 1'b1;
                        in_phase    <= 1'b1;
                        cs_n        <= 1'b0;
                    end else if (phase_done) begin
                        in_phase <= 1'b0;
                        if (!last_phase) begin
                            phase_idx <= phase_idx + 2'd1;
                        end else begin
                            cs_n      <= 1'b1;
                            gap       <= 1'b1;
                            phase_idx <= 2'd0;
                            case (state)
                                WREN:    state <= PROGRAM;
                                PROGRAM: state <= POLL;
                                POLL: begin
                                    flash_status <= phase_rx_word[7:0];
                                    if (!phase_rx_word[0]) begin
                                        state <= DONE;  // write-in-progress cleared
                                    end else if (poll_cnt == PW'(POLL_LIMIT - 1)) begin
                                        error <= 1'b1;
                                        state <= DONE;
                                    end else begin
                                        poll_cnt <= poll_cnt + 1'b1;
                                    end
                                end
                                STATUS: begin
                                    flash_status <= phase_rx_word[7:0];
                                    state        <= DONE;
                                end
                                default: begin
                                    rdata_valid <= 1'b1;  // read or quad read
                                    state       <= DONE;
                                end
                            endcase
                        end
                    end
                end
            endcase
        end
    end

    // command operands and read result
    always_ff @(posedge clk) begin
        if (state == IDLE && cmd_start) begin
            addr_q  <= cmd_addr;
            wdata_q <= cmd_wdata;
        end
        if (frame_end && (state == READ || state == QREAD)) begin
            rdata <= phase_rx_word;
        end
    end

endmodule

//--- hw/wb_flash_regs.sv
`timescale 1ns/1ps

module wb_flash_regs import spi_flash_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  wb_addr_t    wb_adr,
    input  flash_word_t wb_dat_w,
    output flash_word_t wb_dat_r,
    output logic        wb_ack,
    input  logic        busy,
    input  logic        error,
    input  flash_word_t rdata,
    input  logic        rdata_valid,
    input  logic [7:0]  flash_status,
    output logic        cmd_start,
    output logic [1:0]  cmd_code,
    output flash_addr_t cmd_addr,
    output flash_word_t cmd_wdata
);

    flash_word_t rdata_q;
    flash_word_t status_word;
    logic        req;

    // no new request in the ack cycle, so ack never lasts two cycles
    assign req         = wb_cyc && wb_stb && !wb_ack;
    assign status_word = {16'h0000, flash_status, 6'b000000, error, busy};

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_ack    <= 1'b0;
            cmd_start <= 1'b0;
            cmd_code  <= CMD_READ;
        end else begin
            wb_ack    <= req;
            cmd_start <= 1'b0;
            if (req && wb_we && wb_adr == REG_CTRL && !busy) begin
                cmd_code  <= wb_dat_w[1:0];
                cmd_start <= 1'b1;  // writes while busy are acked and dropped
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rdata_valid) begin
            rdata_q <= rdata;
        end
        if (req && wb_we) begin
            case (wb_adr)
                REG_ADDR:  cmd_addr  <= wb_dat_w[23:0];
                REG_WDATA: cmd_wdata <= wb_dat_w;
                default: ;
            endcase
        end
        if (req && !wb_we) begin
            case (wb_adr)
                REG_CTRL:   wb_dat_r <= {30'd0, cmd_code};
                REG_ADDR:   wb_dat_r <= {8'h00, cmd_addr};
                REG_WDATA:  wb_dat_r <= cmd_wdata;
                REG_RDATA:  wb_dat_r <= rdata_q;
                REG_STATUS: wb_dat_r <= status_word;
                default:    wb_dat_r <= '0;
            endcase
        end
    end

endmodule

//--- hw/spi_flash_top.sv
`timescale 1ns/1ps

module spi_flash_top import spi_flash_pkg::*; #(
    parameter int POLL_LIMIT = 64
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  wb_addr_t    wb_adr,
    input  flash_word_t wb_dat_w,
    output flash_word_t wb_dat_r,
    output logic        wb_ack,
    output logic        cs_n,
    output logic        sck,
    output logic [3:0]  dq_out,
    output logic [3:0]  dq_oe,
    input  logic [3:0]  dq_in
);

    logic        cmd_start;
    logic [1:0]  cmd_code;
    flash_addr_t cmd_addr;
    flash_word_t cmd_wdata;
    logic        busy;
    logic        error;
    flash_word_t rdata;
    logic        rdata_valid;
    logic [7:0]  flash_status;
    logic        phase_start;
    logic        phase_rx;
    logic        phase_quad;
    logic [2:0]  phase_bytes;
    flash_word_t phase_tx;
    logic        phase_done;
    flash_word_t phase_rx_word;

    wb_flash_regs u_regs (
        .clk          (clk),
        .reset        (reset),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_we        (wb_we),
        .wb_adr       (wb_adr),
        .wb_dat_w     (wb_dat_w),
        .wb_dat_r     (wb_dat_r),
        .wb_ack       (wb_ack),
        .busy         (busy),
        .error        (error),
        .rdata        (rdata),
        .rdata_valid  (rdata_valid),
        .flash_status (flash_status),
        .cmd_start    (cmd_start),
        .cmd_code     (cmd_code),
        .cmd_addr     (cmd_addr),
        .cmd_wdata    (cmd_wdata)
    );

    flash_sequencer #(
        .POLL_LIMIT (POLL_LIMIT)
    ) u_sequencer (
        .clk           (clk),
        .reset         (reset),
        .cmd_start     (cmd_start),
        .cmd_code      (cmd_code),
        .cmd_addr      (cmd_addr),
        .cmd_wdata     (cmd_wdata),
        .phase_done    (phase_done),
        .phase_rx_word (phase_rx_word),
        .phase_start   (phase_start),
        .phase_rx      (phase_rx),
        .phase_quad    (phase_quad),
        .phase_bytes   (phase_bytes),
        .phase_tx      (phase_tx),
        .cs_n          (cs_n),
        .busy          (busy),
        .cmd_done      (),             // host sees the end through busy
        .rdata         (rdata),
        .rdata_valid   (rdata_valid),
        .flash_status  (flash_status),
        .error         (error)
    );

    spi_shifter u_shifter (
        .clk           (clk),
        .reset         (reset),
        .phase_start   (phase_start),
        .phase_rx      (phase_rx),
        .phase_quad    (phase_quad),
        .phase_bytes   (phase_bytes),
        .phase_tx      (phase_tx),
        .phase_done    (phase_done),
        .phase_rx_word (phase_rx_word),
        .sck           (sck),
        .dq_out        (dq_out),
        .dq_oe         (dq_oe),
        .dq_in         (dq_in)
    );

endmodule

//--- tests/flash_model.sv
`timescale 1ns/1ps

module flash_model import spi_flash_pkg::*; (
    input  logic       cs_n,
    input  logic       sck,
    input  logic [3:0] dq_out,
    input  logic [3:0] dq_oe,
    output logic [3:0] dq_in
);

    logic [7:0]  mem [0:255];
    logic [7:0]  opcode;
    logic [23:0] addr;
    logic [31:0] data_in;
    logic [7:0]  bit_cnt;    // rising sck edges in this frame
    logic [3:0]  drv;
    logic [3:0]  drv_en;
    logic        wel;
    logic        wip;
    int          wip_reads;  // status reads left before wip clears
    logic [7:0]  cur_byte;
    int          pos;
    logic [3:0]  pins;

    // pad ring: flash drive wins, then the controller, else pull-up
    assign pins  = (drv_en & drv) | (~drv_en & dq_oe & dq_out) | (~drv_en & ~dq_oe);
    assign dq_in = pins;

    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[i] = 8'hff;  // erased
        end
        opcode    = 8'h00;
        addr      = 24'h000000;
        data_in   = 32'h00000000;
        bit_cnt   = 8'd0;
        drv       = 4'b1111;
        drv_en    = 4'b0000;
        wel       = 1'b0;
        wip       = 1'b0;
        wip_reads = 0;
    end

    always @(posedge sck or posedge cs_n) begin
        if (cs_n) begin
            // frame ends, commit what the command asked for
            if (opcode == OP_WREN && bit_cnt == 8'd8) begin
                wel <= 1'b1;
            end
            if (opcode == OP_PP && bit_cnt >= 8'd64 && wel) begin
                for (int i = 0; i < 4; i++) begin
                    mem[addr[7:0] + 8'(i)] = mem[addr[7:0] + 8'(i)] & data_in[31 - 8 * i -: 8];
                end
                wip       <= 1'b1;
                wip_reads <= 3;
            end
            if (opcode == OP_RDSR && bit_cnt >= 8'd16 && wip) begin
                wip_reads <= wip_reads - 1;
                if (wip_reads == 1) begin
                    wip <= 1'b0;
                    wel <= 1'b0;  // program finished
                end
            end
            bit_cnt <= 8'd0;
        end else begin
            if (bit_cnt < 8'd8) begin
                opcode <= {opcode[6:0], pins[0]};
            end else if (bit_cnt < 8'd32) begin
                addr <= {addr[22:0], pins[0]};
            end else if (bit_cnt < 8'd64) begin
                data_in <= {data_in[30:0], pins[0]};
            end
            if (bit_cnt != 8'd255) begin
                bit_cnt <= bit_cnt + 8'd1;
            end
        end
    end

    // mode 0, output changes on the falling edge
    always @(negedge sck) begin
        drv_en <= 4'b0000;
        drv    <= 4'b1111;
        if (!cs_n && opcode == OP_READ && bit_cnt >= 8'd32 && bit_cnt < 8'd64) begin
            pos      = int'(bit_cnt) - 32;
            cur_byte = mem[addr[7:0] + 8'(pos / 8)];
            drv      <= {2'b11, cur_byte[7 - pos % 8], 1'b1};
            drv_en   <= 4'b0010;
        end
        if (!cs_n && opcode == OP_QREAD && bit_cnt >= 8'd40 && bit_cnt < 8'd48) begin
            pos      = int'(bit_cnt) - 40;  // eight dummy clocks came before
            cur_byte = mem[addr[7:0] + 8'(pos / 2)];
            drv      <= (pos % 2 == 0) ? cur_byte[7:4] : cur_byte[3:0];
            drv_en   <= 4'b1111;
        end
        if (!cs_n && opcode == OP_RDSR && bit_cnt >= 8'd8 && bit_cnt < 8'd16) begin
            pos      = int'(bit_cnt) - 8;
            cur_byte = {6'b000000, wel, wip};
            drv      <= {2'b11, cur_byte[7 - pos], 1'b1};
            drv_en   <= 4'b0010;
        end
    end

endmodule

//--- tests/tb_spi_flash.sv
`timescale 1ns/1ps

module tb_spi_flash import spi_flash_pkg::*; ();

    localparam int MAX_OPS   = 32;
    localparam int END_KIND  = 15;  // kind of the last vector line
    localparam int KIND_BUSY = 4;   // read with a control write while busy

    logic        clk;
    logic        reset;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    wb_addr_t    wb_adr;
    flash_word_t wb_dat_w;
    flash_word_t wb_dat_r;
    logic        wb_ack;
    logic        cs_n;
    logic        sck;
    logic [3:0]  dq_out;
    logic [3:0]  dq_oe;
    logic [3:0]  dq_in;

    logic [31:0] vec [0:4*MAX_OPS-1];  // kind, address, write word, expected word
    logic [7:0]  shadow [0:255];
    logic [31:0] lfsr;
    int          n_ops;
    int          errors;
    int          checks;
    int          xfers;
    int          acks;
    int unsigned cycles;
    int unsigned cycle_limit;
    logic        ack_prev;
    flash_word_t st0;

    spi_flash_top #(
        .POLL_LIMIT (64)
    ) u_spi_flash_top (
        .clk      (clk),
        .reset    (reset),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .cs_n     (cs_n),
        .sck      (sck),
        .dq_out   (dq_out),
        .dq_oe    (dq_oe),
        .dq_in    (dq_in)
    );

    flash_model u_flash (
        .cs_n   (cs_n),
        .sck    (sck),
        .dq_out (dq_out),
        .dq_oe  (dq_oe),
        .dq_in  (dq_in)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // taps 32, 22, 2, 1
    endfunction

    function automatic flash_word_t shadow_word(input flash_addr_t a);
        flash_word_t w;
        w = '0;
        for (int k = 0; k < 4; k++) begin
            w = {w[23:0], shadow[a[7:0] + 8'(k)]};
        end
        return w;
    endfunction

    task automatic shadow_program(input flash_addr_t a, input flash_word_t d);
        for (int k = 0; k < 4; k++) begin
            shadow[a[7:0] + 8'(k)] = shadow[a[7:0] + 8'(k)] & d[31 - 8 * k -: 8];
        end
    endtask

    task automatic idle_gap();
        int n;
        n = 0;
        for (int k = 0; k < 2; k++) begin
            lfsr = lfsr_step(lfsr);
            n    = n * 2 + int'(lfsr[0]);
        end
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic wait_ack();
        do begin
            @(posedge clk);
            #1;
        end while (!wb_ack);
    endtask

    task automatic write_reg(input wb_addr_t a, input flash_word_t d);
        idle_gap();
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = 1'b1;
        wb_adr   = a;
        wb_dat_w = d;
        xfers++;
        wait_ack();
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic read_reg(input wb_addr_t a, output flash_word_t d);
        idle_gap();
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b0;
        wb_adr = a;
        xfers++;
        wait_ack();
        d      = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
    endtask

    task automatic wait_not_busy(output flash_word_t st);
        flash_word_t s;
        do begin
            read_reg(REG_STATUS, s);
        end while (s[0]);
        st = s;
    endtask

    task automatic check_word(input string what, input flash_word_t got, input flash_word_t exp);
        checks++;
        assert (got == exp) else begin
            errors++;
            $display("[ERROR] %0t: %s got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic run_op(input int i);
        int          kind;
        logic [1:0]  code;
        flash_addr_t a;
        flash_word_t wd;
        flash_word_t exp_file;
        flash_word_t exp;
        flash_word_t got;
        flash_word_t st;
        kind     = int'(vec[4*i]);
        a        = vec[4*i+1][23:0];
        wd       = vec[4*i+2];
        exp_file = vec[4*i+3];
        code     = (kind == KIND_BUSY) ? CMD_READ : 2'(kind);
        write_reg(REG_ADDR, {8'h00, a});
        write_reg(REG_WDATA, wd);
        write_reg(REG_CTRL, {30'd0, code});
        if (kind == KIND_BUSY) begin
            write_reg(REG_CTRL, {30'd0, CMD_PROGRAM});  // must be dropped
        end
        wait_not_busy(st);
        if (code == CMD_PROGRAM) begin
            shadow_program(a, wd);  // erased bytes only lose ones
        end
        if (code == CMD_PROGRAM || code == CMD_STATUS) begin
            exp = 32'h00000000;  // idle, no error, wip and wel clear
            check_word("status register", st, exp);
        end else begin
            exp = shadow_word(a);
            read_reg(REG_RDATA, got);
            check_word(code == CMD_QREAD ? "quad read data" : "read data", got, exp);
        end
        if (kind == KIND_BUSY) begin
            read_reg(REG_CTRL, got);
            check_word("control after busy write", got, {30'd0, CMD_READ});
        end
        checks++;
        assert (exp_file == exp) else begin
            errors++;
            $display("[ERROR] %0t: vector line %0d expects %h, shadow memory gives %h",
                     $time, i, exp_file, exp);
        end
    endtask

    always @(negedge clk) begin
        if (!reset) begin
            if (wb_ack) begin
                acks++;
            end
            assert (!(wb_ack && ack_prev)) else begin
                errors++;
                $display("wb_ack stayed high for two cycles in a row at %0t", $time);
            end
        end
        ack_prev = wb_ack;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycle_limit != 0 && cycles >= cycle_limit) begin
            $display("timeout after %0d cycles, a command never finished", cycles);
            $display("checks %0d, errors %0d", checks, errors + 1);
            $display("Verification failed");
            $finish;
        end
    end

    initial begin
        reset       = 1'b1;
        wb_cyc      = 1'b0;
        wb_stb      = 1'b0;
        wb_we       = 1'b0;
        wb_adr      = '0;
        wb_dat_w    = '0;
        errors      = 0;
        checks      = 0;
        xfers       = 0;
        acks        = 0;
        cycles      = 0;
        cycle_limit = 0;
        ack_prev    = 1'b0;
        lfsr        = 32'hf30a;
        for (int i = 0; i < 256; i++) begin
            shadow[i] = 8'hff;
        end
        $readmemh("tests/flash_vectors.mem", vec);
        n_ops = -1;
        for (int i = MAX_OPS - 1; i >= 0; i--) begin
            if (vec[4*i] == 32'(END_KIND)) begin
                n_ops = i;  // first end line wins
            end
        end
        if (n_ops < 0) begin
            $display("the vector file has no end line, no operations were run");
            errors++;
            n_ops = 0;
        end
        cycle_limit = 2000 * (n_ops + 1);
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
        check_word("pins after reset", {25'd0, cs_n, sck, wb_ack, dq_oe}, 32'h00000040);
        read_reg(REG_STATUS, st0);
        check_word("status after reset", st0, 32'h00000000);
        for (int i = 0; i < n_ops; i++) begin
            run_op(i);
        end
        repeat (4) @(posedge clk);  // a stray ack would still be counted
        #1;
        checks++;
        assert (acks == xfers) else begin
            errors++;
            $display("%0d bus transfers got %0d acks", xfers, acks);
        end
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- tests/flash_vectors.mem
// kind (0 read, 1 quad read, 2 program, 3 status, 4 read with busy ctrl write, f end)
// address, write word, expected word (read data, or REG_STATUS after program/status)
3 000000 00000000 00000000
0 000010 00000000 ffffffff
1 000020 00000000 ffffffff
2 000010 a5c3f00f 00000000
0 000010 00000000 a5c3f00f
1 000010 00000000 a5c3f00f
2 000010 ff0f3c81 00000000
0 000010 00000000 a5033001
1 000010 00000000 a5033001
4 000010 00000000 a5033001
0 000010 00000000 a5033001
2 0000fe 12345678 00000000
1 0000fe 00000000 12345678
3 000000 00000000 00000000
f 000000 00000000 00000000

//--- src.f
hw/spi_flash_pkg.sv
hw/spi_shifter.sv
hw/flash_sequencer.sv
hw/wb_flash_regs.sv
hw/spi_flash_top.sv
tests/flash_model.sv
tests/tb_spi_flash.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       ?= tb_spi_flash
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Verification passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
